//--- all.f
+incdir+rtl
rtl/snow64_ifid_pkg.sv
rtl/snow64_instr_decoder.sv
rtl/snow64_fetch_ctrl.sv
rtl/snow64_stage_ifid.sv
sim/tb_snow64_ifid.sv

//--- rtl/snow64_fetch_ctrl.sv
`timescale 1ns/1ns
`include "snow64_ifid_defines.svh"

module snow64_fetch_ctrl
	import snow64_ifid_pkg::*;
(
	input logic clk,
	input logic rst_n,

	output fetch_req_t fetch_req,
	input logic fetch_ready,
	input fetch_resp_t fetch_resp,

	output logic [`SNOW64_INSTR_WIDTH-1:0] instr_word,
	input decoded_instr_t decoded,

	output issue_t issue,
	input logic issue_ready,

	input redirect_t redirect,
	input logic wb_busy
);

	ifid_state_e state;
	ifid_state_e state_nxt;

	logic [`SNOW64_ADDR_WIDTH-1:0] pc;
	logic [`SNOW64_ADDR_WIDTH-1:0] pc_nxt;
	logic [`SNOW64_ADDR_WIDTH-1:0] pc_plus4;

	logic [`SNOW64_INSTR_WIDTH-1:0] instr_q;
	logic issue_valid_q;
	logic issue_valid_nxt;

	logic fetch_fire;
	logic resp_take;
	logic resp_nop;
	logic issue_fire;

	assign pc_plus4 = pc + `SNOW64_INSTR_BYTES;

	// handshake events
	assign fetch_fire = fetch_req.valid && fetch_ready;
	assign resp_take = (state == st_wait_instr) && fetch_resp.valid;
	assign resp_nop = (fetch_resp.instr == '0);
	assign issue_fire = issue.valid && issue_ready;

	// only one request outstanding, so the address is simply the pc
	assign fetch_req.valid = (state == st_fetch);
	assign fetch_req.addr = pc;

	// decoder sees the captured word
	assign instr_word = instr_q;

	// ctrl reports the return address, everything else its own address
	assign issue.valid = issue_valid_q;
	assign issue.decoded = decoded;
	assign issue.pc_val = (decoded.group == grp_ctrl) ? pc_plus4 : pc;

	always_comb
	begin
		state_nxt = state;
		pc_nxt = pc;
		issue_valid_nxt = issue_valid_q;

		case (state)
			st_fetch:
			begin
				if (fetch_fire)
				begin
					state_nxt = st_wait_instr;
				end
			end

			st_wait_instr:
			begin
				if (fetch_resp.valid)
				begin
					// nop is dropped here and never reaches execute
					if (resp_nop)
					begin
						state_nxt = st_fetch;
						pc_nxt = pc_plus4;
					end
					else
					begin
						state_nxt = st_issue;
						issue_valid_nxt = 1'b1;
					end
				end
			end

			st_issue:
			begin
				if (issue_fire)
				begin
					issue_valid_nxt = 1'b0;
					case (decoded.group)
						grp_ctrl:
						begin
							// pc stays until execute sends the target
							state_nxt = st_wait_redirect;
						end
						grp_load, grp_store:
						begin
							state_nxt = st_wait_ldst0;
							pc_nxt = pc_plus4;
						end
						default:
						begin
							state_nxt = st_fetch;
							pc_nxt = pc_plus4;
						end
					endcase
				end
			end

			st_wait_redirect:
			begin
				if (redirect.valid)
				begin
					state_nxt = st_fetch;
					pc_nxt = redirect.pc;
				end
			end

			st_wait_ldst0:
			begin
				// give write-back one cycle to raise busy
				state_nxt = st_wait_ldst1;
			end

			st_wait_ldst1:
			begin
				if (!wb_busy)
				begin
					state_nxt = st_fetch;
				end
			end

			default:
			begin
				state_nxt = st_fetch;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_fetch;
			pc <= `SNOW64_RESET_PC;
			issue_valid_q <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			pc <= pc_nxt;
			issue_valid_q <= issue_valid_nxt;
		end
	end

	// instruction word held for the whole issue wait
	always_ff @(posedge clk)
	begin
		if (resp_take)
		begin
			instr_q <= fetch_resp.instr;
		end
	end

	// payload frozen under back-pressure
	assert property (@(posedge clk) disable iff (!rst_n)
		(issue.valid && !issue_ready) |=> (issue.valid && $stable(issue)))
		else $error("issue payload changed while waiting for ready");

	// pending request keeps its address until memory takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		(fetch_req.valid && !fetch_ready) |=> (fetch_req.valid && $stable(fetch_req.addr)))
		else $error("fetch request dropped or address changed while waiting");

	// execute only redirects after a control-flow issue
	assert property (@(posedge clk) disable iff (!rst_n)
		redirect.valid |-> (state == st_wait_redirect))
		else $error("redirect seen outside st_wait_redirect");

endmodule

//--- rtl/snow64_ifid_defines.svh
`ifndef SNOW64_IFID_DEFINES_SVH
`define SNOW64_IFID_DEFINES_SVH

// instruction set widths
`define SNOW64_INSTR_WIDTH 32
`define SNOW64_INSTR_BYTES 4
`define SNOW64_ADDR_WIDTH 32
`define SNOW64_DATA_WIDTH 64
`define SNOW64_REG_INDEX_WIDTH 4
`define SNOW64_OPER_WIDTH 5

// first fetch after reset
`define SNOW64_RESET_PC 32'h0000_0000

// field positions in the instruction word
`define SNOW64_GROUP_MSB 31
`define SNOW64_GROUP_LSB 30
`define SNOW64_OPER_MSB 29
`define SNOW64_OPER_LSB 25
`define SNOW64_RA_MSB 24
`define SNOW64_RA_LSB 21
`define SNOW64_RB_MSB 20
`define SNOW64_RB_LSB 17
`define SNOW64_RC_MSB 16
`define SNOW64_RC_LSB 13
`define SNOW64_IMM12_MSB 11
`define SNOW64_IMM12_LSB 0
`define SNOW64_IMM20_MSB 19
`define SNOW64_IMM20_LSB 0

`endif

//--- rtl/snow64_ifid_pkg.sv
`include "snow64_ifid_defines.svh"

package snow64_ifid_pkg;

	// instruction class, taken from the top two bits of the word
	typedef enum logic [1:0]
	{
		grp_alu   = 2'd0,
		grp_ctrl  = 2'd1,
		grp_load  = 2'd2,
		grp_store = 2'd3
	} instr_group_e;

	// fetch/decode sequencing
	typedef enum logic [2:0]
	{
		st_fetch,
		st_wait_instr,
		st_issue,
		st_wait_redirect,
		st_wait_ldst0,
		st_wait_ldst1
	} ifid_state_e;

	// one instruction after field decode
	typedef struct packed
	{
		instr_group_e group;
		logic [`SNOW64_OPER_WIDTH-1:0] oper;
		logic [`SNOW64_REG_INDEX_WIDTH-1:0] ra;
		logic [`SNOW64_REG_INDEX_WIDTH-1:0] rb;
		logic [`SNOW64_REG_INDEX_WIDTH-1:0] rc;
		logic [`SNOW64_DATA_WIDTH-1:0] imm;
		logic nop;
	} decoded_instr_t;

	// request to instruction memory
	typedef struct packed
	{
		logic valid;
		logic [`SNOW64_ADDR_WIDTH-1:0] addr;
	} fetch_req_t;

	// response from instruction memory, never refused
	typedef struct packed
	{
		logic valid;
		logic [`SNOW64_INSTR_WIDTH-1:0] instr;
	} fetch_resp_t;

	// to the execute stage
	typedef struct packed
	{
		logic valid;
		decoded_instr_t decoded;
		logic [`SNOW64_ADDR_WIDTH-1:0] pc_val;
	} issue_t;

	// new program counter computed by execute
	typedef struct packed
	{
		logic valid;
		logic [`SNOW64_ADDR_WIDTH-1:0] pc;
	} redirect_t;

endpackage

//--- rtl/snow64_instr_decoder.sv
`timescale 1ns/1ns
`include "snow64_ifid_defines.svh"

module snow64_instr_decoder
	import snow64_ifid_pkg::*;
(
	input logic [`SNOW64_INSTR_WIDTH-1:0] instr,
	output decoded_instr_t decoded
);

	localparam int IMM12_WIDTH = `SNOW64_IMM12_MSB - `SNOW64_IMM12_LSB + 1;
	localparam int IMM20_WIDTH = `SNOW64_IMM20_MSB - `SNOW64_IMM20_LSB + 1;

	instr_group_e group;
	logic [IMM12_WIDTH-1:0] imm12;
	logic [IMM20_WIDTH-1:0] imm20;
	logic [`SNOW64_DATA_WIDTH-1:0] imm12_sext;
	logic [`SNOW64_DATA_WIDTH-1:0] imm20_sext;
	logic is_nop;

	// raw fields
	assign group = instr_group_e'(instr[`SNOW64_GROUP_MSB:`SNOW64_GROUP_LSB]);
	assign imm12 = instr[`SNOW64_IMM12_MSB:`SNOW64_IMM12_LSB];
	assign imm20 = instr[`SNOW64_IMM20_MSB:`SNOW64_IMM20_LSB];

	// both immediate forms, sign-extended to full data width
	assign imm12_sext = {{(`SNOW64_DATA_WIDTH-IMM12_WIDTH){imm12[IMM12_WIDTH-1]}}, imm12};
	assign imm20_sext = {{(`SNOW64_DATA_WIDTH-IMM20_WIDTH){imm20[IMM20_WIDTH-1]}}, imm20};

	// all-zero word is the nop encoding
	assign is_nop = (instr == '0);

	always_comb
	begin
		decoded.group = group;
		decoded.oper = instr[`SNOW64_OPER_MSB:`SNOW64_OPER_LSB];
		decoded.ra = instr[`SNOW64_RA_MSB:`SNOW64_RA_LSB];
		decoded.rb = instr[`SNOW64_RB_MSB:`SNOW64_RB_LSB];
		decoded.rc = instr[`SNOW64_RC_MSB:`SNOW64_RC_LSB];
		decoded.nop = is_nop;

		// control flow carries the wide branch offset
		case (group)
			grp_ctrl:
			begin
				decoded.imm = imm20_sext;
			end
			default:
			begin
				decoded.imm = imm12_sext;
			end
		endcase
	end

endmodule

//--- rtl/snow64_stage_ifid.sv
`timescale 1ns/1ns
`include "snow64_ifid_defines.svh"

module snow64_stage_ifid
	import snow64_ifid_pkg::*;
(
	input logic clk,
	input logic rst_n,

	// instruction memory
	output fetch_req_t fetch_req,
	input logic fetch_ready,
	input fetch_resp_t fetch_resp,

	// execute stage
	output issue_t issue,
	input logic issue_ready,
	input redirect_t redirect,

	// write-back
	input logic wb_busy
);

	logic [`SNOW64_INSTR_WIDTH-1:0] instr_word;
	decoded_instr_t decoded;

	// pure field decode of the held word
	snow64_instr_decoder u_decoder
	(
		.instr(instr_word),
		.decoded(decoded)
	);

	// sequencing, pc and issue handshake
	snow64_fetch_ctrl u_fetch_ctrl
	(
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch_ready(fetch_ready),
		.fetch_resp(fetch_resp),
		.instr_word(instr_word),
		.decoded(decoded),
		.issue(issue),
		.issue_ready(issue_ready),
		.redirect(redirect),
		.wb_busy(wb_busy)
	);

endmodule

//--- sim/tb_snow64_ifid.sv
`timescale 1ns/1ns
`include "snow64_ifid_defines.svh"

module tb_snow64_ifid
	import snow64_ifid_pkg::*;
();

	localparam int TIMEOUT = 200;
	localparam int IMAGE_WORDS = 1024;
	localparam int TARGET_ISSUES = 400;

	logic clk;
	logic rst_n;
	fetch_req_t fetch_req;
	logic fetch_ready;
	fetch_resp_t fetch_resp;
	issue_t issue;
	logic issue_ready;
	redirect_t redirect;
	logic wb_busy;

	logic [31:0] imem [IMAGE_WORDS];
	logic [31:0] lfsr_state;
	logic [31:0] model_pc;
	int mismatch_count;
	int timeout_count;
	int issued_count;
	int nop_count;

	snow64_stage_ifid dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch_ready(fetch_ready),
		.fetch_resp(fetch_resp),
		.issue(issue),
		.issue_ready(issue_ready),
		.redirect(redirect),
		.wb_busy(wb_busy)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic fill_image();
		logic [1:0] group;
		logic [31:0] body;
		for (int i = 0; i < IMAGE_WORDS; i++)
		begin
			if (rand_bits(3) == 0)
			begin
				imem[i] = '0;
			end
			else
			begin
				group = rand_bits(2);
				// branches rare, roughly one word in sixteen
				if (group == grp_ctrl && rand_bits(2) != 0)
				begin
					group = grp_alu;
				end
				body = rand_bits(30);
				imem[i] = {group, body[29:0]};
			end
		end
	endtask

	// reference decode straight from the instruction format
	function automatic issue_t expected_issue(input logic [31:0] word, input logic [31:0] addr);
		issue_t exp;
		exp.valid = 1'b1;
		exp.decoded.group = instr_group_e'(word[31:30]);
		exp.decoded.oper = word[29:25];
		exp.decoded.ra = word[24:21];
		exp.decoded.rb = word[20:17];
		exp.decoded.rc = word[16:13];
		exp.decoded.nop = 1'b0;
		if (word[31:30] == 2'd1)
		begin
			exp.decoded.imm = {{44{word[19]}}, word[19:0]};
			exp.pc_val = addr + `SNOW64_INSTR_BYTES;
		end
		else
		begin
			exp.decoded.imm = {{52{word[11]}}, word[11:0]};
			exp.pc_val = addr;
		end
		return exp;
	endfunction

	task automatic run_fetch(output logic [31:0] addr, output logic ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		addr = '0;
		fetch_ready <= rand_bits(1);
		while (!ok && cycles < TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
			check_value(issue.valid, 1'b0, "issue valid while fetching");
			if (fetch_req.valid && fetch_ready)
			begin
				ok = 1'b1;
				addr = fetch_req.addr;
				fetch_ready <= 1'b0;
			end
			else
			begin
				fetch_ready <= rand_bits(1);
			end
		end
		if (!ok)
		begin
			timeout_count++;
			$display("Error at %0t ns: no fetch request accepted within %0d cycles",
				$time, TIMEOUT);
		end
	endtask

	// memory answers 1 to 4 cycles after acceptance
	task automatic deliver_response(input logic [31:0] word);
		int latency;
		latency = 1 + rand_bits(2);
		repeat (latency - 1)
		begin
			@(posedge clk);
			check_value(fetch_req.valid, 1'b0, "fetch request while waiting for memory");
		end
		fetch_resp <= {1'b1, word};
		@(posedge clk);
		fetch_resp <= '0;
	endtask

	task automatic run_issue(output issue_t got, output logic ok);
		int cycles;
		logic held;
		issue_t last;
		ok = 1'b0;
		cycles = 0;
		held = 1'b0;
		last = '0;
		got = '0;
		issue_ready <= rand_bits(1);
		while (!ok && cycles < TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
			check_value(fetch_req.valid, 1'b0, "fetch request while issuing");
			if (issue.valid)
			begin
				if (held)
				begin
					check_value(issue, last, "issue payload changed under back-pressure");
				end
				held = 1'b1;
				last = issue;
			end
			if (issue.valid && issue_ready)
			begin
				ok = 1'b1;
				got = issue;
				issue_ready <= 1'b0;
			end
			else
			begin
				issue_ready <= rand_bits(1);
			end
		end
		if (!ok)
		begin
			timeout_count++;
			$display("Error at %0t ns: no issue transfer within %0d cycles", $time, TIMEOUT);
		end
	endtask

	// execute model returns a branch target 1 to 3 cycles later
	task automatic send_redirect(output logic [31:0] target);
		int delay;
		delay = 1 + (rand_bits(2) % 3);
		target = rand_bits(10) << 2;
		repeat (delay - 1)
		begin
			@(posedge clk);
			check_value(fetch_req.valid, 1'b0, "fetch request before redirect");
		end
		redirect <= {1'b1, target};
		@(posedge clk);
		check_value(fetch_req.valid, 1'b0, "fetch request before redirect");
		redirect <= '0;
	endtask

	task automatic hold_writeback();
		int busy;
		busy = rand_bits(3) % 6;
		if (busy > 0)
		begin
			wb_busy <= 1'b1;
			repeat (busy)
			begin
				@(posedge clk);
				check_value(fetch_req.valid, 1'b0, "fetch request while write-back busy");
			end
			wb_busy <= 1'b0;
		end
	endtask

	initial
	begin
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] model_word;
		logic [31:0] target;
		issue_t got;
		issue_t exp;
		logic ok;
		logic aborted;

		rst_n = 1'b0;
		fetch_ready = 1'b0;
		fetch_resp = '0;
		issue_ready = 1'b0;
		redirect = '0;
		wb_busy = 1'b0;
		mismatch_count = 0;
		timeout_count = 0;
		issued_count = 0;
		nop_count = 0;
		aborted = 1'b0;
		lfsr_state = 32'h7b0c_b3ae;
		fill_image();

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		check_value(issue.valid, 1'b0, "issue valid after reset");
		model_pc = `SNOW64_RESET_PC;

		while (!aborted && issued_count < TARGET_ISSUES)
		begin
			run_fetch(addr, ok);
			if (!ok)
			begin
				aborted = 1'b1;
			end
			else
			begin
				check_value(addr, model_pc, "fetch address");
				word = imem[addr[11:2]];
				model_word = imem[model_pc[11:2]];
				deliver_response(word);
				if (model_word == '0)
				begin
					nop_count++;
					model_pc = model_pc + `SNOW64_INSTR_BYTES;
				end
				else
				begin
					run_issue(got, ok);
					if (!ok)
					begin
						aborted = 1'b1;
					end
					else
					begin
						issued_count++;
						exp = expected_issue(model_word, model_pc);
						check_value(got.decoded, exp.decoded, "decoded fields");
						check_value(got.pc_val, exp.pc_val, "pc_val");
						case (model_word[31:30])
							2'd1:
							begin
								send_redirect(target);
								model_pc = target;
							end
							2'd2, 2'd3:
							begin
								hold_writeback();
								model_pc = model_pc + `SNOW64_INSTR_BYTES;
							end
							default:
							begin
								model_pc = model_pc + `SNOW64_INSTR_BYTES;
							end
						endcase
					end
				end
			end
		end

		$display("issued %0d, nops %0d, mismatches %0d, timeouts %0d",
			issued_count, nop_count, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
